// ==== project.f ====
rtl/adc_pkg.sv
rtl/csr_pkg.sv
rtl/lane_deserializer.sv
rtl/sample_fifo.sv
rtl/sample_arbiter.sv
rtl/adc_csr.sv
rtl/adc_readout_top.sv
testbench/adc_readout_assert.sv
testbench/tb_adc_readout.sv

// ==== rtl/adc_csr.sv ====
// single-beat register bus, one response per request a cycle later; unmapped reads return 0
`timescale 1ns/1ps

module adc_csr (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_valid,
    input  csr_pkg::csr_req_t   req,
    output logic                req_ready,
    output logic                rsp_valid,
    output csr_pkg::csr_data_t  rsp_data,
    input  adc_pkg::chan_mask_t overflow,
    input  logic                sample_done,
    output adc_pkg::chan_mask_t enable,
    output logic                adc_clk_en
);

    adc_pkg::chan_mask_t ctrl_next;
    adc_pkg::chan_mask_t status;
    adc_pkg::chan_mask_t status_clr;
    csr_pkg::count_t     count;
    csr_pkg::csr_data_t  rd_data;
    logic                accept;
    logic                wr_ctrl;
    logic                wr_status;

    assign accept    = req_valid && req_ready;
    assign wr_ctrl   = accept && req.write && (req.addr == csr_pkg::ADDR_CTRL);
    assign wr_status = accept && req.write && (req.addr == csr_pkg::ADDR_STATUS);

    // enable mask lives in CTRL bits 3..0
    assign ctrl_next  = wr_ctrl ? req.wdata[adc_pkg::NUM_CHANNELS-1:0] : enable;
    assign status_clr = wr_status ? req.wdata[adc_pkg::NUM_CHANNELS-1:0] : '0;

    always_comb begin
        case (req.addr)
            csr_pkg::ADDR_CTRL:   rd_data = csr_pkg::csr_data_t'(enable);
            csr_pkg::ADDR_STATUS: rd_data = csr_pkg::csr_data_t'(status);
            csr_pkg::ADDR_COUNT:  rd_data = count;
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_ready  <= 1'b0;
            rsp_valid  <= 1'b0;
            enable     <= '0;
            adc_clk_en <= 1'b0;
            status     <= '0;
            count      <= '0;
        end else begin
            req_ready  <= 1'b1;
            rsp_valid  <= accept;
            enable     <= ctrl_next;
            // converter clock runs while any lane is enabled
            adc_clk_en <= |ctrl_next;
            // a new overflow beats a simultaneous clear
            status     <= (status & ~status_clr) | overflow;
            if (sample_done) begin
                count <= count + 1'b1;
            end
        end
    end

    // writes answer with zero data
    always_ff @(posedge clk) begin
        rsp_data <= (accept && !req.write) ? rd_data : '0;
    end

endmodule

// ==== rtl/adc_pkg.sv ====
// lane and sample sizes for a four-channel 12-bit converter; chan_t assumes exactly four lanes
package adc_pkg;

    // converter geometry
    localparam int NUM_CHANNELS = 4;
    localparam int SAMPLE_BITS  = 12;

    // per-channel buffering, must be a power of two
    localparam int FIFO_DEPTH = 4;

    // one converted sample
    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // channel index, wraps naturally over four lanes
    typedef logic [1:0] chan_t;

    // bit position inside a frame, counts up to SAMPLE_BITS
    typedef logic [3:0] bit_cnt_t;

    // one bit per lane
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // sample on the merged output stream, tagged with its lane
    typedef struct packed {
        chan_t   chan;
        sample_t data;
    } out_sample_t;

endpackage

// ==== rtl/adc_readout_top.sv ====
// single clock domain, lanes already single-ended and sampled on clk; no SPI configuration port
`timescale 1ns/1ps

module adc_readout_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  adc_pkg::chan_mask_t  din,
    input  adc_pkg::chan_mask_t  fco,
    output logic                 out_valid,
    output adc_pkg::out_sample_t out_data,
    input  logic                 out_ready,
    input  logic                 req_valid,
    input  csr_pkg::csr_req_t    req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output csr_pkg::csr_data_t   rsp_data,
    output logic                 adc_clk_en
);

    adc_pkg::chan_mask_t                            enable;
    adc_pkg::chan_mask_t                            sample_valid;
    adc_pkg::sample_t [adc_pkg::NUM_CHANNELS-1:0]   sample;
    adc_pkg::chan_mask_t                            overflow;
    adc_pkg::chan_mask_t                            head_valid;
    adc_pkg::sample_t [adc_pkg::NUM_CHANNELS-1:0]   head_data;
    adc_pkg::chan_mask_t                            pop_ready;
    logic                                           sample_done;

    // one deserializer and one FIFO per lane
    for (genvar ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) begin : g_lane
        lane_deserializer u_deser (
            .clk          (clk),
            .rstn         (rstn),
            .din          (din[ch]),
            .fco          (fco[ch]),
            .enable       (enable[ch]),
            .sample_valid (sample_valid[ch]),
            .sample       (sample[ch])
        );

        sample_fifo u_fifo (
            .clk        (clk),
            .rstn       (rstn),
            .push       (sample_valid[ch]),
            .push_data  (sample[ch]),
            .pop_ready  (pop_ready[ch]),
            .head_valid (head_valid[ch]),
            .head_data  (head_data[ch]),
            .overflow   (overflow[ch])
        );
    end

    sample_arbiter u_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .head_valid  (head_valid),
        .head_data   (head_data),
        .pop_ready   (pop_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .sample_done (sample_done)
    );

    adc_csr u_csr (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .overflow    (overflow),
        .sample_done (sample_done),
        .enable      (enable),
        .adc_clk_en  (adc_clk_en)
    );

endmodule

// ==== rtl/csr_pkg.sv ====
// register map for the readout block; word addresses only, no byte enables on the request bus
package csr_pkg;

    typedef logic [1:0]  csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // delivered-sample counter, wraps silently
    typedef logic [31:0] count_t;

    // word addresses
    localparam csr_addr_t ADDR_CTRL   = 2'd0;
    localparam csr_addr_t ADDR_STATUS = 2'd1;
    localparam csr_addr_t ADDR_COUNT  = 2'd2;

    // one request beat on the valid/ready bus
    typedef struct packed {
        logic      write;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

endpackage

// ==== rtl/lane_deserializer.sv ====
// lane bits arrive MSB first, already sampled on clk; fco marks the MSB and a frame needs 12 bits
`timescale 1ns/1ps

module lane_deserializer (
    input  logic             clk,
    input  logic             rstn,
    input  logic             din,
    input  logic             fco,
    input  logic             enable,
    output logic             sample_valid,
    output adc_pkg::sample_t sample
);

    // bits collected so far, zero while idle
    adc_pkg::bit_cnt_t                   bit_cnt;
    logic [adc_pkg::SAMPLE_BITS-2:0]     shift_reg;
    logic                                frame_en;
    logic                                last_bit;

    // the 12th bit of the frame is on din this cycle
    assign last_bit = !fco
        && (bit_cnt == adc_pkg::bit_cnt_t'(adc_pkg::SAMPLE_BITS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bit_cnt      <= '0;
            frame_en     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (fco) begin
                // new frame, an unfinished one is thrown away
                bit_cnt  <= adc_pkg::bit_cnt_t'(1);
                frame_en <= enable;
            end else if (last_bit) begin
                bit_cnt      <= '0;
                sample_valid <= frame_en;
            end else if (bit_cnt != '0) begin
                bit_cnt <= bit_cnt + adc_pkg::bit_cnt_t'(1);
            end
        end
    end

    // data path runs every cycle
    always_ff @(posedge clk) begin
        shift_reg <= {shift_reg[adc_pkg::SAMPLE_BITS-3:0], din};
        if (last_bit) begin
            sample <= {shift_reg, din};
        end
    end

endmodule

// ==== rtl/sample_arbiter.sv ====
// round-robin over four lanes into one registered output; no lane priority beyond the rotation
`timescale 1ns/1ps

module sample_arbiter (
    input  logic                                            clk,
    input  logic                                            rstn,
    input  adc_pkg::chan_mask_t                             head_valid,
    input  adc_pkg::sample_t [adc_pkg::NUM_CHANNELS-1:0]    head_data,
    output adc_pkg::chan_mask_t                             pop_ready,
    output logic                                            out_valid,
    output adc_pkg::out_sample_t                            out_data,
    input  logic                                            out_ready,
    output logic                                            sample_done
);

    adc_pkg::chan_t last_grant;
    adc_pkg::chan_t grant;
    logic           grant_found;
    logic           load_en;

    // output register is free or emptying this cycle
    assign load_en     = !out_valid || out_ready;
    assign sample_done = out_valid && out_ready;

    // search starts one past the last lane served
    always_comb begin
        adc_pkg::chan_t cand;
        grant       = last_grant;
        grant_found = 1'b0;
        for (int i = 1; i <= adc_pkg::NUM_CHANNELS; i++) begin
            cand = last_grant + adc_pkg::chan_t'(i);
            if (!grant_found && head_valid[cand]) begin
                grant       = cand;
                grant_found = 1'b1;
            end
        end
    end

    always_comb begin
        pop_ready = '0;
        if (load_en && grant_found) begin
            pop_ready[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid  <= 1'b0;
            // so lane 0 is served first
            last_grant <= adc_pkg::chan_t'(adc_pkg::NUM_CHANNELS - 1);
        end else if (load_en) begin
            out_valid <= grant_found;
            if (grant_found) begin
                last_grant <= grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && grant_found) begin
            out_data.chan <= grant;
            out_data.data <= head_data[grant];
        end
    end

endmodule

// ==== rtl/sample_fifo.sv ====
// FIFO_DEPTH must be a power of two; a push into a full buffer is lost even if a pop is pending
`timescale 1ns/1ps

module sample_fifo (
    input  logic             clk,
    input  logic             rstn,
    input  logic             push,
    input  adc_pkg::sample_t push_data,
    input  logic             pop_ready,
    output logic             head_valid,
    output adc_pkg::sample_t head_data,
    output logic             overflow
);

    adc_pkg::sample_t                           mem [adc_pkg::FIFO_DEPTH];
    logic [$clog2(adc_pkg::FIFO_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(adc_pkg::FIFO_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(adc_pkg::FIFO_DEPTH+1)-1:0]   fill;
    logic                                       full;
    logic                                       do_push;
    logic                                       do_pop;

    assign full       = (fill == adc_pkg::FIFO_DEPTH);
    assign head_valid = (fill != '0);
    assign head_data  = mem[rd_ptr];
    assign do_push    = push && !full;
    assign do_pop     = head_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && full;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // fill only moves when exactly one side is active
            if (do_push && !do_pop) begin
                fill <= fill + 1'b1;
            end else if (do_pop && !do_push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator from project.f, run the testbench, decide the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_adc_readout

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_adc_readout -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== testbench/adc_readout_assert.sv ====
// protocol rules on the readout top; single clock, synchronous active-low reset
`timescale 1ns/1ps

module adc_readout_assert (
    input logic                 clk,
    input logic                 rstn,
    input logic                 out_valid,
    input adc_pkg::out_sample_t out_data,
    input logic                 out_ready,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 rsp_valid
);

    // number of rule violations so far
    int fail_count = 0;

    // a stalled sample stays put until taken
    a_out_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else begin
        fail_count++;
        $error("output sample changed or dropped while stalled");
    end

    // one response exactly a cycle after each accepted request
    a_rsp_follows: assert property (
        @(posedge clk) disable iff (!rstn)
        req_valid && req_ready |=> rsp_valid
    ) else begin
        fail_count++;
        $error("no response one cycle after an accepted request");
    end

    a_rsp_has_req: assert property (
        @(posedge clk) disable iff (!rstn)
        rsp_valid |-> $past(req_valid && req_ready)
    ) else begin
        fail_count++;
        $error("response without an accepted request one cycle before");
    end

    // both valids leave reset low
    a_reset_quiet: assert property (
        @(posedge clk)
        !rstn |=> !out_valid && !rsp_valid
    ) else begin
        fail_count++;
        $error("valid output high in the cycle after reset");
    end

endmodule

bind adc_readout_top adc_readout_assert u_assert (
    .clk       (clk),
    .rstn      (rstn),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid)
);

// ==== testbench/tb_adc_readout.sv ====
// inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_adc_readout;

    logic                 clk = 1'b0;
    logic                 rstn;
    adc_pkg::chan_mask_t  din;
    adc_pkg::chan_mask_t  fco;
    logic                 out_valid;
    adc_pkg::out_sample_t out_data;
    logic                 out_ready = 1'b0;
    logic                 req_valid;
    csr_pkg::csr_req_t    req;
    logic                 req_ready;
    logic                 rsp_valid;
    csr_pkg::csr_data_t   rsp_data;
    logic                 adc_clk_en;

    // words waiting to be serialized and words expected at the output
    adc_pkg::sample_t     lane_q   [adc_pkg::NUM_CHANNELS][$];
    adc_pkg::sample_t     expect_q [adc_pkg::NUM_CHANNELS][$];
    // lanes granted while a lane kept waiting
    adc_pkg::chan_mask_t  skipped_by [adc_pkg::NUM_CHANNELS] = '{default: '0};
    adc_pkg::chan_t       last_chan = '0;
    adc_pkg::chan_t       first_lane;
    csr_pkg::csr_data_t   rd;
    int                   ready_mode = 0;
    int                   mode_now;
    int                   errors = 0;
    int                   err_mark = 0;
    int                   assert_seen = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   handshakes = 0;
    int                   wait_limit = 2000;
    logic                 timed_out = 1'b0;

    always #2 clk = ~clk;

    adc_readout_top u_dut (.*);

    // ready is low in mode 0 and high in mode 1 and random otherwise
    always @(posedge clk) begin
        mode_now = ready_mode;
        #1;
        case (mode_now)
            0:       out_ready = 1'b0;
            1:       out_ready = 1'b1;
            default: out_ready = ($urandom_range(1) != 0);
        endcase
    end

    function automatic void log_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        errors++;
    endfunction

    function automatic void note_timeout(input string what);
        if (!timed_out) $display("timeout: no %s within %0d cycles", what, wait_limit);
        timed_out = 1'b1;
        errors++;
    endfunction

    // scoreboard sees at most one handshake per falling edge
    always @(negedge clk) begin
        if (rstn && out_valid && out_ready) begin
            handshakes++;
            last_chan = out_data.chan;
            assert (expect_q[out_data.chan].size() != 0)
                else log_error($sformatf("unexpected sample %h on lane %0d",
                                         out_data.data, out_data.chan));
            if (expect_q[out_data.chan].size() != 0) begin
                assert (out_data.data == expect_q[out_data.chan][0])
                    else log_error($sformatf("lane %0d sample %h, expected %h", out_data.chan,
                                             out_data.data, expect_q[out_data.chan][0]));
                void'(expect_q[out_data.chan].pop_front());
            end
        end
    end

    // a waiting lane must be served before any other lane is granted again
    always @(negedge clk) begin
        if (rstn && (u_dut.pop_ready != '0)) begin
            for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
                if (u_dut.pop_ready[c] || !u_dut.head_valid[c]) begin
                    skipped_by[c] = '0;
                end else begin
                    assert ((skipped_by[c] & u_dut.pop_ready) == '0)
                        else log_error($sformatf("lane %0d passed over twice by one lane", c));
                    skipped_by[c] = skipped_by[c] | u_dut.pop_ready;
                end
            end
        end
    end

    task automatic bus_access(input logic wr, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::csr_data_t wdata);
        int cnt;
        cnt       = 0;
        req_valid = 1'b1;
        req       = '{write: wr, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!req_ready && !timed_out && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt == wait_limit) note_timeout("request acceptance");
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        cnt       = 0;
        @(negedge clk);
        while (!rsp_valid && !timed_out && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt == wait_limit) note_timeout("register response");
        rd = rsp_data;
        @(posedge clk);
        #1;
    endtask

    task automatic check_reg(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t expected);
        bus_access(1'b0, addr, '0);
        assert (rd == expected)
            else log_error($sformatf("register %0d read %h, expected %h", addr, rd, expected));
    endtask

    task automatic write_ctrl(input adc_pkg::chan_mask_t mask);
        bus_access(1'b1, csr_pkg::ADDR_CTRL, csr_pkg::csr_data_t'(mask));
        // converter clock runs exactly while some lane is enabled
        assert (adc_clk_en == (mask != '0))
            else log_error($sformatf("adc_clk_en %b with enable mask %b", adc_clk_en, mask));
    endtask

    task automatic queue_word(input int ch, input logic expected);
        adc_pkg::sample_t w;
        w = adc_pkg::sample_t'($urandom);
        lane_q[ch].push_back(w);
        if (expected) expect_q[ch].push_back(w);
    endtask

    // one frame per lane in parallel with fco on the MSB
    task automatic send_frames();
        adc_pkg::sample_t    word [adc_pkg::NUM_CHANNELS];
        adc_pkg::chan_mask_t active;
        forever begin
            for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) begin
                active[ch] = (lane_q[ch].size() != 0);
                word[ch]   = '0;
                if (active[ch]) word[ch] = lane_q[ch].pop_front();
            end
            if (active == '0) break;
            for (int b = adc_pkg::SAMPLE_BITS - 1; b >= 0; b--) begin
                fco = (b == adc_pkg::SAMPLE_BITS - 1) ? active : '0;
                for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) din[ch] = word[ch][b];
                @(posedge clk);
                #1;
            end
        end
        fco = '0;
        din = '0;
    endtask

    function automatic logic lanes_drained();
        for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) begin
            if (expect_q[ch].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (!lanes_drained() && !timed_out && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt == wait_limit) note_timeout("drain of expected samples");
        // stray samples would show up in this quiet window
        repeat (8) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        // failures of the bound protocol checker count against the test
        errors      += u_dut.u_assert.fail_count - assert_seen;
        assert_seen  = u_dut.u_assert.fail_count;
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors != err_mark) ? "FAIL" : "ok");
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(32'h9390233f));
        rstn      = 1'b0;
        din       = '0;
        fco       = '0;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!out_valid) else log_error("out_valid high after reset");
        end
        @(posedge clk);
        #1;
        check_reg(csr_pkg::ADDR_CTRL, '0);
        check_reg(csr_pkg::ADDR_STATUS, '0);
        check_reg(csr_pkg::ADDR_COUNT, '0);
        finish_test("reset state");

        // lane 2 enabled and lane 0 driven while disabled
        ready_mode = 1;
        write_ctrl(4'b0100);
        for (int i = 0; i < 3; i++) begin
            queue_word(2, 1'b1);
            queue_word(0, 1'b0);
        end
        send_frames();
        wait_drain();
        finish_test("single lane");

        ready_mode = 2;
        write_ctrl('1);
        for (int i = 0; i < 6; i++) begin
            for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) queue_word(ch, 1'b1);
        end
        send_frames();
        wait_drain();
        finish_test("all lanes");

        // the lane after the last one served fills the stalled output register
        // so its FIFO holds one word more than the others
        ready_mode = 0;
        first_lane = last_chan + adc_pkg::chan_t'(1);
        for (int i = 0; i < adc_pkg::FIFO_DEPTH + 3; i++) begin
            for (int ch = 0; ch < adc_pkg::NUM_CHANNELS; ch++) begin
                queue_word(ch, (i < adc_pkg::FIFO_DEPTH)
                    || (i == adc_pkg::FIFO_DEPTH && adc_pkg::chan_t'(ch) == first_lane));
            end
        end
        send_frames();
        check_reg(csr_pkg::ADDR_STATUS, 32'hf);
        bus_access(1'b1, csr_pkg::ADDR_STATUS, 32'hf);
        check_reg(csr_pkg::ADDR_STATUS, '0);
        ready_mode = 1;
        wait_drain();
        finish_test("back-pressure and overflow");

        check_reg(csr_pkg::ADDR_COUNT, csr_pkg::csr_data_t'(handshakes));
        finish_test("sample count");

        write_ctrl(4'b0001);
        write_ctrl('0);
        finish_test("clock enable");

        $display("summary: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
